// ==== include/frontendParams_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

`define ADDR_W 32

`define INST_W 32

// pc + 8 steps over the delay slot
`define FALL_OFFSET 8

// counter value for a fresh NLP entry
`define BIM_WEAK_NT 2'b01

`endif

// ==== hdl/fetchPkg.sv ====
`default_nettype none
`include "frontendParams_params.svh"

package fetchPkg;

    // one instruction slot as it leaves stage 2
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] pc;
        logic [`INST_W-1:0] inst;
        logic               nlpValid;    // next-line predictor hit
        logic               nlpTaken;
        logic [`ADDR_W-1:0] nlpTarget;
        logic [1:0]         nlpBimState;
    } fetchSlot;

    typedef struct packed {
        logic               isJ;     // any jump, jr included
        logic               isBr;    // conditional branch
        logic               isJr;    // register jump
        logic [`ADDR_W-1:0] target;  // static target, not valid for jr
    } predecodeInfo;

endpackage

`default_nettype wire

// ==== hdl/predictPkg.sv ====
`default_nettype none
`include "frontendParams_params.svh"

package predictPkg;

    typedef struct packed {
        logic valid;
        logic taken;
    } bpdInfo;

    // training write back to the NLP
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] pc;
        logic [`ADDR_W-1:0] target;
        logic [1:0]         bimState;
        logic               shouldTake;
    } nlpUpdate;

endpackage

`default_nettype wire

// ==== hdl/predecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frontendParams_params.svh"

module predecoder (
    input  wire logic [`ADDR_W-1:0] pc,
    input  wire logic [`INST_W-1:0] inst,
    input  wire logic               valid,
    output fetchPkg::predecodeInfo  info
);
    logic [5:0]         opcode;
    logic [4:0]         rt;
    logic [5:0]         funct;
    logic [`ADDR_W-1:0] pcPlus4;
    logic [`ADDR_W-1:0] jumpTarget;
    logic [`ADDR_W-1:0] branchTarget;
    logic               isJImm;
    logic               isJReg;
    logic               isBranch;

    assign opcode  = inst[31:26];
    assign rt      = inst[20:16];
    assign funct   = inst[5:0];
    assign pcPlus4 = pc + 4;

    assign jumpTarget   = {pcPlus4[`ADDR_W-1:28], inst[25:0], 2'b00};  // region of pc+4
    assign branchTarget = pcPlus4 + {{(`ADDR_W-18){inst[15]}}, inst[15:0], 2'b00};

    assign isJImm = (opcode == 6'b000010) || (opcode == 6'b000011);  // j, jal
    assign isJReg = (opcode == 6'b000000) &&
                    ((funct == 6'b001000) || (funct == 6'b001001));  // jr, jalr

    // beq bne blez bgtz, then bltz bgez bltzal bgezal
    assign isBranch = (opcode[5:2] == 4'b0001) ||
                      ((opcode == 6'b000001) && (rt[3:1] == 3'b000));

    always_comb begin
        info.isJ    = valid && (isJImm || isJReg);
        info.isJr   = valid && isJReg;
        info.isBr   = valid && isBranch;
        info.target = isBranch ? branchTarget : jumpTarget;
    end

endmodule

`default_nettype wire

// ==== hdl/fetchPipeReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchPipeReg (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire logic               pause,
    input  wire logic               flush,
    input  wire fetchPkg::fetchSlot in0,
    input  wire fetchPkg::fetchSlot in1,
    output fetchPkg::fetchSlot      stage0,
    output fetchPkg::fetchSlot      stage1
);
    fetchPkg::fetchSlot [1:0] pairQ;
    logic [1:0]               validQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= '0;
        end else if (flush) begin
            validQ <= '0;  // flush wins over pause
        end else if (!pause) begin
            validQ <= {in1.valid, in0.valid};
        end
    end

    always_ff @(posedge clk) begin
        if (!pause) begin
            pairQ <= {in1, in0};
        end
    end

    always_comb begin
        stage0       = pairQ[0];
        stage0.valid = validQ[0];
        stage1       = pairQ[1];
        stage1.valid = validQ[1];
    end

endmodule

`default_nettype wire

// ==== hdl/branchResolve.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frontendParams_params.svh"

module branchResolve (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   pause,
    input  wire logic                   flush,
    input  wire fetchPkg::fetchSlot     stage0,
    input  wire fetchPkg::fetchSlot     stage1,
    input  wire fetchPkg::predecodeInfo pre0,
    input  wire fetchPkg::predecodeInfo pre1,
    input  wire predictPkg::bpdInfo     bpd0,
    input  wire predictPkg::bpdInfo     bpd1,
    output logic                        out0Valid,
    output logic [`ADDR_W-1:0]          out0Pc,
    output logic [`INST_W-1:0]          out0Inst,
    output logic                        out0PredTaken,
    output logic [`ADDR_W-1:0]          out0PredAddr,
    output logic                        out1Valid,
    output logic [`ADDR_W-1:0]          out1Pc,
    output logic [`INST_W-1:0]          out1Inst,
    output logic                        out1PredTaken,
    output logic [`ADDR_W-1:0]          out1PredAddr,
    output logic                        redirect,
    output logic [`ADDR_W-1:0]          redirectPc,
    output logic                        flushReq,
    output logic                        nlpUpdValid,
    output logic [`ADDR_W-1:0]          nlpUpdPc,
    output logic [`ADDR_W-1:0]          nlpUpdTarget,
    output logic [1:0]                  nlpUpdBimState,
    output logic                        nlpUpdShouldTake
);
    fetchPkg::fetchSlot     slot [2];
    fetchPkg::predecodeInfo pre  [2];
    predictPkg::bpdInfo     bpd  [2];
    logic [`ADDR_W-1:0]     predAddr [2];
    logic [`ADDR_W-1:0]     fixPc    [2];
    logic [1:0]             live;
    logic [1:0]             jumpTaken;
    logic [1:0]             predTaken;
    logic [1:0]             nlpTaken;
    logic [1:0]             missTaken;
    logic [1:0]             missFall;
    logic [1:0]             missTarget;
    logic [1:0]             eligible;
    logic                   mismatch0;
    logic                   startWait;
    logic                   waitDs;
    logic                   lastWaitDs;
    logic [`ADDR_W-1:0]     waitTarget;
    logic                   updSel;
    predictPkg::nlpUpdate   upd;

    assign slot[0] = stage0;
    assign slot[1] = stage1;
    assign pre[0]  = pre0;
    assign pre[1]  = pre1;
    assign bpd[0]  = bpd0;
    assign bpd[1]  = bpd1;

    // slot 1 is dead while waiting on the delay slot and one cycle after
    assign live[0] = slot[0].valid;
    assign live[1] = slot[1].valid && !(waitDs || lastWaitDs);

    for (genvar i = 0; i < 2; i++) begin : gSlot
        assign predAddr[i]  = pre[i].isJr ? slot[i].nlpTarget : pre[i].target;
        assign jumpTaken[i] = pre[i].isJ && !(pre[i].isJr && !slot[i].nlpValid);
        assign predTaken[i] = !slot[i].valid ? 1'b0 :
                              jumpTaken[i]   ? 1'b1 :
                              !pre[i].isBr   ? 1'b0 :
                              bpd[i].valid   ? bpd[i].taken :
                              slot[i].nlpValid && slot[i].nlpTaken;
        assign nlpTaken[i]   = slot[i].valid && slot[i].nlpValid && slot[i].nlpTaken;
        assign missTaken[i]  = predTaken[i] && !nlpTaken[i];
        assign missFall[i]   = !predTaken[i] && nlpTaken[i];
        assign missTarget[i] = predTaken[i] && nlpTaken[i] &&
                               (predAddr[i] != slot[i].nlpTarget);
        assign fixPc[i]      = missFall[i] ? slot[i].pc + `FALL_OFFSET : predAddr[i];
        assign eligible[i]   = live[i] && (bpd[i].valid || jumpTaken[i]);
    end

    assign mismatch0 = missTaken[0] || missFall[0] || missTarget[0];
    assign startWait = !waitDs && !mismatch0 && live[1] &&
                       (missTaken[1] || missTarget[1] ||
                        (missFall[1] && (pre[1].isJ || pre[1].isBr)));

    always_comb begin
        redirect   = 1'b0;
        redirectPc = '0;
        if (!pause && !flush) begin
            if (waitDs) begin
                redirect   = slot[0].valid;  // delay slot has arrived
                redirectPc = waitTarget;
            end else if (mismatch0) begin
                redirect   = 1'b1;
                redirectPc = fixPc[0];
            end
        end
    end

    assign flushReq = redirect;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waitDs     <= 1'b0;
            lastWaitDs <= 1'b0;
        end else if (flush) begin
            waitDs     <= 1'b0;
            lastWaitDs <= 1'b0;
        end else if (!pause) begin
            waitDs     <= waitDs ? !slot[0].valid : startWait;
            lastWaitDs <= waitDs;
        end
    end

    always_ff @(posedge clk) begin
        if (startWait && !pause && !flush) begin
            waitTarget <= fixPc[1];
        end
    end

    assign updSel = !eligible[0];  // oldest eligible slot trains

    always_comb begin
        upd = '0;
        if (|eligible) begin
            upd.valid      = 1'b1;
            upd.pc         = slot[updSel].pc;
            upd.target     = predAddr[updSel];
            upd.bimState   = slot[updSel].nlpValid ? slot[updSel].nlpBimState : `BIM_WEAK_NT;
            upd.shouldTake = predTaken[updSel];
        end
    end

    assign nlpUpdValid      = upd.valid;
    assign nlpUpdPc         = upd.pc;
    assign nlpUpdTarget     = upd.target;
    assign nlpUpdBimState   = upd.bimState;
    assign nlpUpdShouldTake = upd.shouldTake;

    assign out0Valid     = live[0];
    assign out0Pc        = slot[0].pc;
    assign out0Inst      = slot[0].inst;
    assign out0PredTaken = predTaken[0];
    assign out0PredAddr  = predAddr[0];
    assign out1Valid     = live[1];
    assign out1Pc        = slot[1].pc;
    assign out1Inst      = slot[1].inst;
    assign out1PredTaken = predTaken[1];
    assign out1PredAddr  = predAddr[1];

endmodule

`default_nettype wire

// ==== hdl/fetchStage3.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frontendParams_params.svh"

module fetchStage3 (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire logic               pause,
    input  wire logic               flush,
    input  wire logic               in0Valid,
    input  wire logic [`ADDR_W-1:0] in0Pc,
    input  wire logic [`INST_W-1:0] in0Inst,
    input  wire logic               in0NlpValid,
    input  wire logic               in0NlpTaken,
    input  wire logic [`ADDR_W-1:0] in0NlpTarget,
    input  wire logic [1:0]         in0NlpBimState,
    input  wire logic               in1Valid,
    input  wire logic [`ADDR_W-1:0] in1Pc,
    input  wire logic [`INST_W-1:0] in1Inst,
    input  wire logic               in1NlpValid,
    input  wire logic               in1NlpTaken,
    input  wire logic [`ADDR_W-1:0] in1NlpTarget,
    input  wire logic [1:0]         in1NlpBimState,
    input  wire logic               bpd0Valid,
    input  wire logic               bpd0Taken,
    input  wire logic               bpd1Valid,
    input  wire logic               bpd1Taken,
    output logic                    out0Valid,
    output logic [`ADDR_W-1:0]      out0Pc,
    output logic [`INST_W-1:0]      out0Inst,
    output logic                    out0PredTaken,
    output logic [`ADDR_W-1:0]      out0PredAddr,
    output logic                    out1Valid,
    output logic [`ADDR_W-1:0]      out1Pc,
    output logic [`INST_W-1:0]      out1Inst,
    output logic                    out1PredTaken,
    output logic [`ADDR_W-1:0]      out1PredAddr,
    output logic                    redirect,
    output logic [`ADDR_W-1:0]      redirectPc,
    output logic                    flushReq,
    output logic                    nlpUpdValid,
    output logic [`ADDR_W-1:0]      nlpUpdPc,
    output logic [`ADDR_W-1:0]      nlpUpdTarget,
    output logic [1:0]              nlpUpdBimState,
    output logic                    nlpUpdShouldTake
);
    fetchPkg::fetchSlot     in0Slot;
    fetchPkg::fetchSlot     in1Slot;
    fetchPkg::fetchSlot     stage0;
    fetchPkg::fetchSlot     stage1;
    fetchPkg::predecodeInfo pre0Info;
    fetchPkg::predecodeInfo pre1Info;
    predictPkg::bpdInfo     bpd0Info;
    predictPkg::bpdInfo     bpd1Info;

    assign in0Slot = '{valid: in0Valid, pc: in0Pc, inst: in0Inst, nlpValid: in0NlpValid,
                       nlpTaken: in0NlpTaken, nlpTarget: in0NlpTarget,
                       nlpBimState: in0NlpBimState};
    assign in1Slot = '{valid: in1Valid, pc: in1Pc, inst: in1Inst, nlpValid: in1NlpValid,
                       nlpTaken: in1NlpTaken, nlpTarget: in1NlpTarget,
                       nlpBimState: in1NlpBimState};
    assign bpd0Info = '{valid: bpd0Valid, taken: bpd0Taken};  // lines up with stage0
    assign bpd1Info = '{valid: bpd1Valid, taken: bpd1Taken};

    fetchPipeReg pipeReg (
        .clk    (clk),
        .rstN   (rstN),
        .pause  (pause),
        .flush  (flush),
        .in0    (in0Slot),
        .in1    (in1Slot),
        .stage0 (stage0),
        .stage1 (stage1)
    );

    predecoder pre0 (
        .pc    (stage0.pc),
        .inst  (stage0.inst),
        .valid (stage0.valid),
        .info  (pre0Info)
    );

    predecoder pre1 (
        .pc    (stage1.pc),
        .inst  (stage1.inst),
        .valid (stage1.valid),
        .info  (pre1Info)
    );

    branchResolve resolve (
        .clk              (clk),
        .rstN             (rstN),
        .pause            (pause),
        .flush            (flush),
        .stage0           (stage0),
        .stage1           (stage1),
        .pre0             (pre0Info),
        .pre1             (pre1Info),
        .bpd0             (bpd0Info),
        .bpd1             (bpd1Info),
        .out0Valid        (out0Valid),
        .out0Pc           (out0Pc),
        .out0Inst         (out0Inst),
        .out0PredTaken    (out0PredTaken),
        .out0PredAddr     (out0PredAddr),
        .out1Valid        (out1Valid),
        .out1Pc           (out1Pc),
        .out1Inst         (out1Inst),
        .out1PredTaken    (out1PredTaken),
        .out1PredAddr     (out1PredAddr),
        .redirect         (redirect),
        .redirectPc       (redirectPc),
        .flushReq         (flushReq),
        .nlpUpdValid      (nlpUpdValid),
        .nlpUpdPc         (nlpUpdPc),
        .nlpUpdTarget     (nlpUpdTarget),
        .nlpUpdBimState   (nlpUpdBimState),
        .nlpUpdShouldTake (nlpUpdShouldTake)
    );

endmodule

`default_nettype wire

// ==== test/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);
    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;  // released after two rising edges
    end

    always #4 clk = ~clk;  // 8 ns period

endmodule

`default_nettype wire

// ==== test/fetchStage3_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage3_props (
    input wire logic clk,
    input wire logic rstN,
    input wire logic pause,
    input wire logic flush,
    input wire logic redirect,
    input wire logic flushReq,
    input wire logic nlpUpdValid,
    input wire logic out0Valid,
    input wire logic out1Valid,
    input wire logic waitDs
);
    int failCount = 0;  // read by the testbench summary

    redirectMatchesFlush: assert property (@(posedge clk) redirect == flushReq)
        else begin
            failCount++;
            $error("redirect and flushReq differ");
        end

    quietWhileStalled: assert property (@(posedge clk) (pause || flush) |-> !redirect)
        else begin
            failCount++;
            $error("redirect raised during pause or flush");
        end

    quietInReset: assert property (@(posedge clk)
        !rstN |-> !(redirect || flushReq || nlpUpdValid || out0Valid || out1Valid))
        else begin
            failCount++;
            $error("control output high in reset");
        end

    // slot 1 stays dead right after the delay slot redirect
    slot1DeadAfterWait: assert property (@(posedge clk) disable iff (!rstN)
        (redirect && waitDs) |=> !out1Valid)
        else begin
            failCount++;
            $error("out1Valid high after a delay slot redirect");
        end

endmodule

bind fetchStage3 fetchStage3_props props_i (
    .clk         (clk),
    .rstN        (rstN),
    .pause       (pause),
    .flush       (flush),
    .redirect    (redirect),
    .flushReq    (flushReq),
    .nlpUpdValid (nlpUpdValid),
    .out0Valid   (out0Valid),
    .out1Valid   (out1Valid),
    .waitDs      (resolve.waitDs)
);

`default_nettype wire

// ==== test/fetchStage3_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage3_tb;
    logic        clk;
    logic        rstN;
    logic        pause;
    logic        flush;
    logic        in0Valid;
    logic [31:0] in0Pc;
    logic [31:0] in0Inst;
    logic        in0NlpValid;
    logic        in0NlpTaken;
    logic [31:0] in0NlpTarget;
    logic [1:0]  in0NlpBimState;
    logic        in1Valid;
    logic [31:0] in1Pc;
    logic [31:0] in1Inst;
    logic        in1NlpValid;
    logic        in1NlpTaken;
    logic [31:0] in1NlpTarget;
    logic [1:0]  in1NlpBimState;
    logic        bpd0Valid;
    logic        bpd0Taken;
    logic        bpd1Valid;
    logic        bpd1Taken;
    logic        out0Valid;
    logic [31:0] out0Pc;
    logic [31:0] out0Inst;
    logic        out0PredTaken;
    logic [31:0] out0PredAddr;
    logic        out1Valid;
    logic [31:0] out1Pc;
    logic [31:0] out1Inst;
    logic        out1PredTaken;
    logic [31:0] out1PredAddr;
    logic        redirect;
    logic [31:0] redirectPc;
    logic        flushReq;
    logic        nlpUpdValid;
    logic [31:0] nlpUpdPc;
    logic [31:0] nlpUpdTarget;
    logic [1:0]  nlpUpdBimState;
    logic        nlpUpdShouldTake;

    logic [31:0] lfsr = 32'hd362;
    int          errors = 0;
    int          testCount = 0;
    int          testStartErrors = 0;

    tbClock clkGen (.clk(clk), .rstN(rstN));

    fetchStage3 dut_i (.*);

    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr   = lfsr >> 1;
        if (outBit) lfsr = lfsr ^ 32'h80200003;  // galois taps 32 22 2 1
        return outBit;
    endfunction

    function automatic logic [31:0] randWord(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) w = {w[30:0], lfsrBit()};
        return w;
    endfunction

    function automatic logic [31:0] jumpTarget(input logic [31:0] pc, input logic [25:0] idx);
        logic [31:0] p4;
        p4 = pc + 32'd4;
        return {p4[31:28], idx, 2'b00};
    endfunction

    function automatic logic [31:0] branchTarget(input logic [31:0] pc, input logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic clearInputs();
        {pause, flush, bpd0Valid, bpd0Taken, bpd1Valid, bpd1Taken} = '0;
        {in0Valid, in0Pc, in0Inst, in0NlpValid, in0NlpTaken, in0NlpTarget, in0NlpBimState} = '0;
        {in1Valid, in1Pc, in1Inst, in1NlpValid, in1NlpTaken, in1NlpTarget, in1NlpBimState} = '0;
    endtask

    task automatic setSlot0(input logic v, input logic [31:0] pc, input logic [31:0] inst,
                            input logic nv, input logic nt, input logic [31:0] tgt,
                            input logic [1:0] bim);
        {in0Valid, in0Pc, in0Inst, in0NlpValid, in0NlpTaken, in0NlpTarget, in0NlpBimState} =
            {v, pc, inst, nv, nt, tgt, bim};
    endtask

    task automatic setSlot1(input logic v, input logic [31:0] pc, input logic [31:0] inst,
                            input logic nv, input logic nt, input logic [31:0] tgt,
                            input logic [1:0] bim);
        {in1Valid, in1Pc, in1Inst, in1NlpValid, in1NlpTaken, in1NlpTarget, in1NlpBimState} =
            {v, pc, inst, nv, nt, tgt, bim};
    endtask

    // one edge later, back on the falling edge where outputs are settled
    task automatic nextCycle();
        @(negedge clk);
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("%s: %s", name, (errors == testStartErrors) ? "pass" : "fail");
        testStartErrors = errors;
        clearInputs();
        nextCycle();
        nextCycle();
    endtask

    // a mismatching branch in slot 1 behind a plain slot 0
    task automatic startSlot1Wait(output logic [31:0] target);
        logic [31:0] pc;
        logic [15:0] off;
        logic [31:0] inst;
        pc   = randWord(30) << 2;
        off  = 16'(randWord(16));
        inst = {6'b000101, 10'(randWord(10)), off};
        setSlot0(1'b1, pc, {6'b001001, 26'(randWord(26))}, 1'b0, 1'b0, '0, 2'b00);
        setSlot1(1'b1, pc + 32'd4, inst, 1'b0, 1'b0, '0, 2'b00);
        {bpd1Valid, bpd1Taken} = 2'b11;
        target = branchTarget(pc + 32'd4, off);
        nextCycle();
        checkBit("redirect", redirect, 1'b0);
        checkBit("out1Valid", out1Valid, 1'b1);
        checkBit("out1PredTaken", out1PredTaken, 1'b1);
        checkWord("out1PredAddr", out1PredAddr, target);
        checkWord("out1Pc", out1Pc, pc + 32'd4);
        checkWord("out1Inst", out1Inst, inst);
    endtask

    initial begin
        int          waitCycles;
        logic [31:0] pc;
        logic [31:0] tgt;
        logic [25:0] idx;
        logic [15:0] off;

        clearInputs();
        waitCycles = 0;
        while (rstN !== 1'b1 && waitCycles < 20) begin
            nextCycle();
            waitCycles++;
        end
        if (rstN !== 1'b1) begin
            errors++;
            $display("timed out waiting for reset to be released");
        end
        nextCycle();

        pc  = randWord(30) << 2;
        idx = 26'(randWord(26));
        setSlot0(1'b1, pc, {6'b000010, idx}, 1'b0, 1'b0, '0, 2'b00);
        nextCycle();
        checkBit("redirect", redirect, 1'b1);
        checkWord("redirectPc", redirectPc, jumpTarget(pc, idx));
        checkWord("out0Pc", out0Pc, pc);
        checkWord("out0Inst", out0Inst, {6'b000010, idx});
        checkBit("nlpUpdValid", nlpUpdValid, 1'b1);
        checkWord("nlpUpdPc", nlpUpdPc, pc);
        checkWord("nlpUpdBimState", {30'd0, nlpUpdBimState}, 32'd1);
        checkBit("nlpUpdShouldTake", nlpUpdShouldTake, 1'b1);
        endTest("jump in slot 0 with nlp miss");

        pc  = randWord(30) << 2;
        setSlot0(1'b1, pc, {6'b001001, 26'(randWord(26))}, 1'b1, 1'b1, randWord(30) << 2,
                 2'b10);
        nextCycle();
        checkBit("redirect", redirect, 1'b1);
        checkWord("redirectPc", redirectPc, pc + 32'd8);
        checkBit("out0PredTaken", out0PredTaken, 1'b0);
        endTest("false nlp taken on plain instruction");

        pc  = randWord(30) << 2;
        off = 16'(randWord(16));
        tgt = branchTarget(pc, off);
        setSlot0(1'b1, pc, {6'b000100, 10'(randWord(10)), off}, 1'b1, 1'b0, '0, 2'b10);
        {bpd0Valid, bpd0Taken} = 2'b11;
        nextCycle();
        checkBit("redirect", redirect, 1'b1);
        checkWord("redirectPc", redirectPc, tgt);
        setSlot0(1'b1, pc, {6'b000100, 10'd0, off}, 1'b1, 1'b1, tgt, 2'b11);
        nextCycle();
        checkBit("redirect", redirect, 1'b0);
        checkBit("out0PredTaken", out0PredTaken, 1'b1);
        setSlot0(1'b1, pc, {6'b000100, 10'd0, off}, 1'b0, 1'b0, '0, 2'b00);
        {bpd0Valid, bpd0Taken} = 2'b00;
        nextCycle();
        checkBit("out0PredTaken", out0PredTaken, 1'b0);
        checkBit("redirect", redirect, 1'b0);
        endTest("branch with bpd and nlp");

        startSlot1Wait(tgt);
        setSlot0(1'b0, '0, '0, 1'b0, 1'b0, '0, 2'b00);  // bpd1 stays with the branch
        setSlot1(1'b1, randWord(30) << 2, {6'b001001, 26'd0}, 1'b0, 1'b0, '0, 2'b00);
        for (int i = 0; i < 2; i++) begin
            nextCycle();
            checkBit("redirect", redirect, 1'b0);
            checkBit("out1Valid", out1Valid, 1'b0);
        end
        setSlot0(1'b1, randWord(30) << 2, {6'b001001, 26'd0}, 1'b0, 1'b0, '0, 2'b00);
        nextCycle();
        checkBit("redirect", redirect, 1'b1);
        checkWord("redirectPc", redirectPc, tgt);
        nextCycle();
        checkBit("redirect", redirect, 1'b0);
        checkBit("out1Valid", out1Valid, 1'b0);
        nextCycle();
        checkBit("out1Valid", out1Valid, 1'b1);
        endTest("slot 1 mismatch waits for delay slot");

        startSlot1Wait(tgt);
        pc = randWord(30) << 2;
        setSlot0(1'b1, pc, {6'b001001, 26'd0}, 1'b0, 1'b0, '0, 2'b00);
        setSlot1(1'b1, pc + 32'd4, {6'b001001, 26'd0}, 1'b0, 1'b0, '0, 2'b00);
        nextCycle();  // wait flag up with the delay slot in slot 0
        pause = 1'b1;
        setSlot0(1'b1, pc + 32'd16, {6'b001001, 26'd0}, 1'b0, 1'b0, '0, 2'b00);
        for (int i = 0; i < 2; i++) begin
            nextCycle();
            checkBit("redirect", redirect, 1'b0);
            checkWord("out0Pc", out0Pc, pc);
            checkBit("out1Valid", out1Valid, 1'b0);
        end
        pause = 1'b0;
        flush = 1'b1;
        nextCycle();
        checkBit("redirect", redirect, 1'b0);
        checkBit("out0Valid", out0Valid, 1'b0);
        flush = 1'b0;
        nextCycle();
        checkBit("out0Valid", out0Valid, 1'b1);
        checkWord("out0Pc", out0Pc, pc + 32'd16);
        checkBit("redirect", redirect, 1'b0);
        endTest("pause and flush during wait");

        pc  = randWord(30) << 2;
        tgt = randWord(30) << 2;
        setSlot0(1'b1, pc, {6'b000000, 5'(randWord(5)), 15'd0, 6'b001000}, 1'b1, 1'b1, tgt,
                 2'b11);
        nextCycle();
        checkWord("out0PredAddr", out0PredAddr, tgt);
        checkBit("out0PredTaken", out0PredTaken, 1'b1);
        checkBit("redirect", redirect, 1'b0);
        checkBit("nlpUpdValid", nlpUpdValid, 1'b1);
        checkWord("nlpUpdPc", nlpUpdPc, pc);
        checkWord("nlpUpdTarget", nlpUpdTarget, tgt);
        checkWord("nlpUpdBimState", {30'd0, nlpUpdBimState}, 32'd3);
        endTest("jr with nlp hit");

        $display("tests %0d, check errors %0d, assertion failures %0d",
                 testCount, errors, dut_i.props_i.failCount);
        if (errors == 0 && dut_i.props_i.failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hdl/fetchPkg.sv
hdl/predictPkg.sv
hdl/predecoder.sv
hdl/fetchPipeReg.sv
hdl/branchResolve.sv
hdl/fetchStage3.sv
test/tbClock.sv
test/fetchStage3_props.sv
test/fetchStage3_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fetchStage3_tb -f flist.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep "Test completed successfully" > /dev/null

clean:
	rm -rf obj_dir
